// ==== cpu_top.f ====
logic/cpu_isa_pkg.sv
logic/cpu_mem_pkg.sv
logic/reg_file.sv
logic/alu.sv
logic/instr_fetch.sv
logic/exec_core.sv
logic/data_ram.sv
logic/cpu_top.sv
dv/cpu_assertions.sv
dv/cpu_tb.sv

// ==== dv/cpu_assertions.sv ====
`default_nettype none
`timescale 1ns/1ns

module cpu_assertions
    import cpu_mem_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input mem_store_t store,
    input logic       illegal
);

    // nothing leaves the core while held in reset
    store_quiet_in_reset: assert property (
        @(posedge clk) !rst_n |-> !store.en
    ) else $error("store.en high while rst_n is low");

    // illegal is a single-cycle pulse per bad opcode
    illegal_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) illegal |=> !illegal
    ) else $error("illegal held high for two cycles");

    // at most one store per instruction, instructions take 4+ cycles
    stores_spaced: assert property (
        @(posedge clk) disable iff (!rst_n) store.en |=> !store.en
    ) else $error("store.en high in two consecutive cycles");

endmodule

`default_nettype wire

// ==== dv/cpu_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

module cpu_tb
    import cpu_isa_pkg::*;
    import cpu_mem_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 2;
    // executed instruction counts of the directed programs
    localparam int N_ARITH = 10;
    localparam int N_LOAD = 5;
    localparam int N_JZI = 19;
    localparam int N_JZR = 8;
    localparam int N_ILLEGAL = 7;
    localparam int RAND_TESTS = 20;
    localparam int RAND_BODY = 8;
    localparam int RAND_INSTRS = RAND_BODY + REG_COUNT;
    localparam int NUM_TESTS = 5 + RAND_TESTS;
    localparam int TOTAL_INSTRS = N_ARITH + N_LOAD + N_JZI + N_JZR + N_ILLEGAL
                                  + RAND_TESTS * RAND_INSTRS;
    // reset, full image load and drain per test
    localparam int SETUP_CYCLES = RESET_CYCLES + MEM_DEPTH + 8;
    // worst case 5 cycles per instruction
    localparam int WATCHDOG_NS = (TOTAL_INSTRS * 5 + NUM_TESTS * SETUP_CYCLES + 200)
                                 * CLK_PERIOD;

    logic       clk;
    logic       rst_n;
    logic       run;
    mem_load_t  load;
    mem_store_t store;
    logic       illegal;

    // program image and the reference copy that it mutates
    logic [MEM_DATA_BITS-1:0] image [MEM_DEPTH];
    logic [MEM_DATA_BITS-1:0] ref_mem [MEM_DEPTH];
    mem_store_t               exp_q [$];

    int     errors;
    int     checks;
    int     tests_run;
    int     tests_failed;
    int     ill_count;
    int     store_count;
    integer seed;

    cpu_top i_cpu_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .run     (run),
        .load    (load),
        .store   (store),
        .illegal (illegal)
    );

    bind cpu_top cpu_assertions i_cpu_assertions (
        .clk     (clk),
        .rst_n   (rst_n),
        .store   (store),
        .illegal (illegal)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // rd rs imm layout, rt sits in imm[7:6]
    function automatic logic [15:0] encode(opcode_e op, int rd, int rs, logic [7:0] imm);
        instr_t w;
        w.opcode = op;
        w.rd     = rd[1:0];
        w.rs     = rs[1:0];
        w.rt     = imm[7:6];
        w.rest   = imm[5:0];
        return w;
    endfunction

    function automatic logic [15:0] rr_form(opcode_e op, int rd, int rs, int rt);
        return encode(op, rd, rs, 8'(rt << 6));
    endfunction

    // instruction k lives at bytes 2k (high) and 2k+1 (low)
    task automatic place_instr(input int idx, input logic [15:0] word);
        image[2 * idx]     = word[15:8];
        image[2 * idx + 1] = word[7:0];
    endtask

    // background pattern over the whole image
    task automatic fill_image();
        for (int a = 0; a < MEM_DEPTH; a++) begin
            image[a] = 8'(a) ^ 8'ha5;
        end
    endtask

    // ISA interpreter, fills exp_q and returns the illegal count
    function automatic int reference_run(int n_instr);
        logic [7:0]  regs [REG_COUNT];
        logic [7:0]  ip;
        logic [7:0]  hi;
        logic [7:0]  imm;
        logic [7:0]  res;
        logic        zf;
        instr_t      ins;
        mem_store_t  st;
        int          n_illegal;
        for (int a = 0; a < MEM_DEPTH; a++) begin
            ref_mem[a] = image[a];
        end
        for (int r = 0; r < REG_COUNT; r++) begin
            regs[r] = '0;
        end
        ip        = '0;
        zf        = 1'b0;
        n_illegal = 0;
        exp_q.delete();
        for (int k = 0; k < n_instr; k++) begin
            // two byte fetch, ip moves past the instruction
            hi  = ref_mem[ip];
            ip  = ip + 8'd1;
            ins = instr_t'({hi, ref_mem[ip]});
            ip  = ip + 8'd1;
            imm = ins[7:0];
            case (ins.opcode)
                MOVIR: regs[ins.rd] = imm;
                MOVRR: regs[ins.rd] = regs[ins.rs];
                MOVMR: regs[ins.rd] = ref_mem[imm];
                MOVRM: begin
                    ref_mem[imm] = regs[ins.rd];
                    st.en        = 1'b1;
                    st.addr      = imm;
                    st.data      = regs[ins.rd];
                    exp_q.push_back(st);
                end
                ADDRR, SUBRR, ADDI, SUBI: begin
                    if (ins.opcode == ADDRR) begin
                        res = regs[ins.rs] + regs[ins.rt];
                    end else if (ins.opcode == SUBRR) begin
                        res = regs[ins.rs] - regs[ins.rt];
                    end else if (ins.opcode == ADDI) begin
                        res = regs[ins.rd] + imm;
                    end else begin
                        res = regs[ins.rd] - imm;
                    end
                    regs[ins.rd] = res;
                    zf           = (res == 8'd0);
                end
                // signed offset from the ip after fetch
                JZI: if (zf) ip = 8'(int'(ip) + int'($signed(imm)));
                JZR: if (zf) ip = regs[ins.rs];
                NOP: ;
                default: n_illegal++;
            endcase
        end
        return n_illegal;
    endfunction

    task automatic check_store(input mem_store_t got, input mem_store_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t ns: store addr %02h data %02h, expected addr %02h data %02h",
                     $time, got.addr, got.data, exp.addr, exp.data);
        end
    endtask

    task automatic check_illegal(input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("** Error @ %0t ns: illegal pulses %0d, expected %0d", $time, got, exp);
        end
    endtask

    // compare stores against the reference as they happen
    always @(negedge clk) begin
        if (rst_n && store.en) begin
            store_count++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("store to %02h at %0t ns was not expected by the reference",
                         store.addr, $time);
            end else begin
                check_store(store, exp_q.pop_front());
            end
        end
        if (rst_n && illegal) begin
            ill_count++;
        end
    end

    task automatic apply_reset();
        @(negedge clk);
        run   = 1'b0;
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // whole image each time, RAM keeps contents over reset
    task automatic load_image();
        for (int a = 0; a < MEM_DEPTH; a++) begin
            @(negedge clk);
            load.en   = 1'b1;
            load.addr = 8'(a);
            load.data = image[a];
        end
        @(negedge clk);
        load = '0;
    endtask

    task automatic run_program(input string name, input int n_instr);
        int exp_illegal;
        int err_start;
        int done_count;
        exp_illegal = reference_run(n_instr);
        err_start   = errors;
        apply_reset();
        load_image();
        ill_count   = 0;
        store_count = 0;
        done_count  = 0;
        @(negedge clk);
        run = 1'b1;
        // drop run on the last exec_done so fetch halts after it
        while (done_count < n_instr) begin
            @(negedge clk);
            if (i_cpu_top.exec_done) begin
                done_count++;
            end
        end
        run = 1'b0;
        repeat (3) @(negedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%s: %0d expected stores never appeared", name, exp_q.size());
        end
        check_illegal(ill_count, exp_illegal);
        tests_run++;
        if (errors != err_start) begin
            tests_failed++;
        end
        $display("test %s %s  instrs %0d  stores %0d  illegal %0d", name,
                 (errors == err_start) ? "ok" : "FAILED", n_instr, store_count, ill_count);
    endtask

    // arithmetic body then store every register
    task automatic build_random();
        opcode_e ops [6] = '{MOVIR, MOVRR, ADDRR, ADDI, SUBRR, SUBI};
        int      pick;
        int      rd;
        int      rs;
        fill_image();
        for (int k = 0; k < RAND_BODY; k++) begin
            pick = int'($unsigned($random(seed)) % 6);
            rd   = int'($unsigned($random(seed)) % REG_COUNT);
            rs   = int'($unsigned($random(seed)) % REG_COUNT);
            place_instr(k, encode(ops[pick], rd, rs, 8'($random(seed))));
        end
        for (int r = 0; r < REG_COUNT; r++) begin
            place_instr(RAND_BODY + r, encode(MOVRM, r, 0, 8'(8'hc0 + r)));
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        run          = 1'b0;
        load         = '0;
        seed         = 32'h971b;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        ill_count    = 0;
        store_count  = 0;

        // immediates and all four add/sub forms
        fill_image();
        place_instr(0, encode(MOVIR, 0, 0, 8'h12));
        place_instr(1, encode(MOVIR, 1, 0, 8'h34));
        place_instr(2, rr_form(ADDRR, 2, 0, 1));
        place_instr(3, encode(MOVRM, 2, 0, 8'h80));
        place_instr(4, encode(ADDI, 0, 0, 8'h0f));
        place_instr(5, encode(MOVRM, 0, 0, 8'h81));
        place_instr(6, rr_form(SUBRR, 3, 1, 0));
        place_instr(7, encode(MOVRM, 3, 0, 8'h82));
        place_instr(8, encode(SUBI, 1, 0, 8'h40));
        place_instr(9, encode(MOVRM, 1, 0, 8'h83));
        run_program("arith", N_ARITH);

        // loads from preloaded data, copy, store
        fill_image();
        image[8'h90] = 8'ha7;
        place_instr(0, encode(MOVMR, 1, 0, 8'h90));
        place_instr(1, encode(MOVRR, 2, 1, 8'h00));
        place_instr(2, encode(MOVRM, 2, 0, 8'h84));
        place_instr(3, encode(MOVMR, 3, 0, 8'h91));
        place_instr(4, encode(MOVRM, 3, 0, 8'h85));
        run_program("load", N_LOAD);

        // count down loop, forward exit and backward jump
        fill_image();
        place_instr(0, encode(MOVIR, 0, 0, 8'd3));
        place_instr(1, encode(MOVIR, 1, 0, 8'd0));
        place_instr(2, encode(ADDI, 1, 0, 8'd1));
        place_instr(3, encode(MOVRM, 1, 0, 8'h88));
        place_instr(4, encode(SUBI, 0, 0, 8'd1));
        place_instr(5, encode(JZI, 0, 0, 8'd4));
        place_instr(6, rr_form(SUBRR, 3, 3, 3));
        place_instr(7, encode(JZI, 0, 0, 8'hf4));
        place_instr(8, encode(MOVRM, 1, 0, 8'h89));
        run_program("jzi", N_JZI);

        // first JZR falls through on the reset flag
        fill_image();
        place_instr(0, encode(MOVIR, 2, 0, 8'h10));
        place_instr(1, encode(MOVIR, 0, 0, 8'd1));
        place_instr(2, encode(JZR, 0, 2, 8'h00));
        place_instr(3, encode(MOVRM, 0, 0, 8'h8a));
        place_instr(4, encode(SUBI, 0, 0, 8'd1));
        place_instr(5, encode(JZR, 0, 2, 8'h00));
        place_instr(6, encode(MOVRM, 0, 0, 8'h8b));
        place_instr(7, encode(MOVRM, 0, 0, 8'h8b));
        place_instr(8, encode(MOVIR, 3, 0, 8'h77));
        place_instr(9, encode(MOVRM, 3, 0, 8'h8c));
        run_program("jzr", N_JZR);

        // opcodes 11, 15 and 14 between real work
        fill_image();
        place_instr(0, encode(MOVIR, 0, 0, 8'h5c));
        place_instr(1, 16'hb000);
        place_instr(2, encode(MOVRM, 0, 0, 8'h8d));
        place_instr(3, 16'hf3ff);
        place_instr(4, encode(ADDI, 0, 0, 8'd1));
        place_instr(5, 16'he000);
        place_instr(6, encode(MOVRM, 0, 0, 8'h8e));
        run_program("illegal", N_ILLEGAL);

        for (int t = 0; t < RAND_TESTS; t++) begin
            build_random();
            run_program($sformatf("rand%0d", t), RAND_INSTRS);
        end

        $display("tests %0d  failed %0d  checks %0d  errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the DUT stopped finishing instructions",
                 WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`default_nettype none
`timescale 1ns/1ns

module alu
    import cpu_isa_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [DATA_BITS-1:0] a,
    input  logic [DATA_BITS-1:0] b,
    input  logic                 subtract,
    input  logic                 flag_en,
    output logic [DATA_BITS-1:0] result,
    output logic                 zero
);

    // 8-bit wraparound, no carry kept
    assign result = subtract ? (a - b) : (a + b);

    // zero flag only moves on add/subtract
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            zero <= 1'b0;
        end else if (flag_en) begin
            zero <= (result == '0);
        end
    end

endmodule

`default_nettype wire

// ==== logic/cpu_isa_pkg.sv ====
`default_nettype none

package cpu_isa_pkg;

    // register file shape
    localparam int REG_COUNT = 4;
    localparam int REG_ADDR_BITS = 2;
    localparam int DATA_BITS = 8;

    // instruction field widths
    localparam int OPCODE_BITS = 4;
    localparam int IMM_BITS = 8;

    // opcode values 0..10, anything above is illegal
    typedef enum logic [OPCODE_BITS-1:0] {
        MOVIR = 4'd0,
        MOVRR = 4'd1,
        MOVMR = 4'd2,
        MOVRM = 4'd3,
        ADDRR = 4'd4,
        ADDI  = 4'd5,
        SUBRR = 4'd6,
        SUBI  = 4'd7,
        JZI   = 4'd8,
        JZR   = 4'd9,
        NOP   = 4'd10
    } opcode_e;

    // 16-bit instruction word, high byte fetched first
    // imm8 overlays rt and rest (bits 7:0)
    typedef struct packed {
        opcode_e                  opcode;
        logic [REG_ADDR_BITS-1:0] rd;
        logic [REG_ADDR_BITS-1:0] rs;
        logic [REG_ADDR_BITS-1:0] rt;
        logic [5:0]               rest;
    } instr_t;

endpackage

`default_nettype wire

// ==== logic/cpu_mem_pkg.sv ====
`default_nettype none

package cpu_mem_pkg;

    // shared 256-byte RAM
    localparam int MEM_ADDR_BITS = 8;
    localparam int MEM_DATA_BITS = 8;
    localparam int MEM_DEPTH = 1 << MEM_ADDR_BITS;
    localparam int IP_BITS = 8;

    // one RAM access from fetch or execute
    typedef struct packed {
        logic                     re;
        logic                     we;
        logic [MEM_ADDR_BITS-1:0] addr;
        logic [MEM_DATA_BITS-1:0] data;
    } mem_req_t;

    // preload port, only honoured while run is low
    typedef struct packed {
        logic                     en;
        logic [MEM_ADDR_BITS-1:0] addr;
        logic [MEM_DATA_BITS-1:0] data;
    } mem_load_t;

    // completed store, visible at the top level
    typedef struct packed {
        logic                     en;
        logic [MEM_ADDR_BITS-1:0] addr;
        logic [MEM_DATA_BITS-1:0] data;
    } mem_store_t;

    // branch outcome from execute back to fetch
    typedef struct packed {
        logic               taken;
        logic [IP_BITS-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

// ==== logic/cpu_top.sv ====
`default_nettype none
`timescale 1ns/1ns

module cpu_top
    import cpu_isa_pkg::*;
    import cpu_mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       run,
    input  mem_load_t  load,
    output mem_store_t store,
    output logic       illegal
);

    mem_req_t                 fetch_req;
    mem_req_t                 exec_req;
    logic [MEM_DATA_BITS-1:0] rd_data;
    logic                     instr_valid;
    instr_t                   instr;
    logic                     exec_done;
    redirect_t                redirect;

    instr_fetch i_instr_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .rd_data     (rd_data),
        .exec_done   (exec_done),
        .redirect    (redirect),
        .fetch_req   (fetch_req),
        .instr_valid (instr_valid),
        .instr       (instr)
    );

    // fetch address doubles as ip after fetch for JZI
    exec_core i_exec_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rd_data     (rd_data),
        .exec_req    (exec_req),
        .store       (store),
        .exec_done   (exec_done),
        .redirect    (redirect),
        .next_ip     (fetch_req.addr),
        .illegal     (illegal)
    );

    data_ram i_data_ram (
        .clk       (clk),
        .run       (run),
        .load      (load),
        .fetch_req (fetch_req),
        .exec_req  (exec_req),
        .rd_data   (rd_data)
    );

endmodule

`default_nettype wire

// ==== logic/data_ram.sv ====
`default_nettype none
`timescale 1ns/1ns

module data_ram
    import cpu_mem_pkg::*;
(
    input  logic                     clk,
    input  logic                     run,
    input  mem_load_t                load,
    input  mem_req_t                 fetch_req,
    input  mem_req_t                 exec_req,
    output logic [MEM_DATA_BITS-1:0] rd_data
);

    logic [MEM_DATA_BITS-1:0] mem [MEM_DEPTH];
    mem_req_t                 req;

    // port select
    // fetch is idle whenever execute drives the port
    always_comb begin
        if (!run && load.en) begin
            req.re   = 1'b0;
            req.we   = 1'b1;
            req.addr = load.addr;
            req.data = load.data;
        end else if (exec_req.re || exec_req.we) begin
            req = exec_req;
        end else begin
            req = fetch_req;
        end
    end

    // contents survive reset
    always_ff @(posedge clk) begin
        if (req.we) begin
            mem[req.addr] <= req.data;
        end
    end

    // rd_data holds until the next read
    always_ff @(posedge clk) begin
        if (req.re) begin
            rd_data <= mem[req.addr];
        end
    end

endmodule

`default_nettype wire

// ==== logic/exec_core.sv ====
`default_nettype none
`timescale 1ns/1ns

module exec_core
    import cpu_isa_pkg::*;
    import cpu_mem_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     instr_valid,
    input  instr_t                   instr,
    input  logic [MEM_DATA_BITS-1:0] rd_data,
    output mem_req_t                 exec_req,
    output mem_store_t               store,
    output logic                     exec_done,
    output redirect_t                redirect,
    input  logic [IP_BITS-1:0]       next_ip,
    output logic                     illegal
);

    typedef enum logic [1:0] {
        EX_IDLE,
        EX_RUN,
        EX_LOAD
    } state_e;

    state_e               state;
    instr_t               ir;
    logic                 active;
    logic [IMM_BITS-1:0]  imm8;
    logic [DATA_BITS-1:0] reg_rs;
    logic [DATA_BITS-1:0] reg_rt;
    logic [DATA_BITS-1:0] reg_rd;
    logic [DATA_BITS-1:0] alu_a;
    logic [DATA_BITS-1:0] alu_b;
    logic [DATA_BITS-1:0] alu_result;
    logic                 subtract;
    logic                 flag_en;
    logic                 zero;
    logic                 wr_en;
    logic [DATA_BITS-1:0] wr_data;

    // one instruction at a time, MOVMR takes an extra cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= EX_IDLE;
        end else begin
            case (state)
                EX_IDLE: begin
                    if (instr_valid) begin
                        state <= EX_RUN;
                    end
                end
                EX_RUN: begin
                    state <= (ir.opcode == MOVMR) ? EX_LOAD : EX_IDLE;
                end
                default: begin
                    state <= EX_IDLE;
                end
            endcase
        end
    end

    // instr is only valid in the issue cycle, keep a copy
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            ir <= instr;
        end
    end

    assign active = (state == EX_RUN);
    assign imm8   = ir[IMM_BITS-1:0];

    reg_file i_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (ir.rs),
        .rt_addr (ir.rt),
        .rd_addr (ir.rd),
        .rs_data (reg_rs),
        .rt_data (reg_rt),
        .rd_data (reg_rd),
        .wr_en   (wr_en),
        .wr_addr (ir.rd),
        .wr_data (wr_data)
    );

    alu i_alu (
        .clk      (clk),
        .rst_n    (rst_n),
        .a        (alu_a),
        .b        (alu_b),
        .subtract (subtract),
        .flag_en  (flag_en),
        .result   (alu_result),
        .zero     (zero)
    );

    // decode, everything qualified by active
    always_comb begin
        alu_a           = reg_rs;
        alu_b           = reg_rt;
        subtract        = 1'b0;
        flag_en         = 1'b0;
        wr_en           = 1'b0;
        wr_data         = alu_result;
        illegal         = 1'b0;
        redirect.taken  = 1'b0;
        redirect.target = next_ip;
        exec_req.re     = 1'b0;
        exec_req.we     = 1'b0;
        store.en        = 1'b0;
        case (ir.opcode)
            MOVIR: begin
                wr_en   = active;
                wr_data = imm8;
            end
            MOVRR: begin
                wr_en   = active;
                wr_data = reg_rs;
            end
            MOVMR: begin
                exec_req.re = active;
            end
            MOVRM: begin
                exec_req.we = active;
                store.en    = active;
            end
            ADDRR, SUBRR: begin
                subtract = (ir.opcode == SUBRR);
                wr_en    = active;
                flag_en  = active;
            end
            ADDI, SUBI: begin
                // rd is both source and destination
                alu_a    = reg_rd;
                alu_b    = imm8;
                subtract = (ir.opcode == SUBI);
                wr_en    = active;
                flag_en  = active;
            end
            JZI: begin
                // 8-bit wrap gives the signed offset
                redirect.taken  = active && zero;
                redirect.target = next_ip + imm8;
            end
            JZR: begin
                redirect.taken  = active && zero;
                redirect.target = reg_rs;
            end
            NOP: begin
            end
            default: begin
                illegal = active;
            end
        endcase
        // load data arrives one cycle after the read
        if (state == EX_LOAD) begin
            wr_en   = 1'b1;
            wr_data = rd_data;
        end
    end

    // store goes out on the RAM port and to the top at once
    assign exec_req.addr = imm8;
    assign exec_req.data = reg_rd;
    assign store.addr    = imm8;
    assign store.data    = reg_rd;

    assign exec_done = (active && (ir.opcode != MOVMR)) || (state == EX_LOAD);

endmodule

`default_nettype wire

// ==== logic/instr_fetch.sv ====
`default_nettype none
`timescale 1ns/1ns

module instr_fetch
    import cpu_isa_pkg::*;
    import cpu_mem_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     run,
    input  logic [MEM_DATA_BITS-1:0] rd_data,
    input  logic                     exec_done,
    input  redirect_t                redirect,
    output mem_req_t                 fetch_req,
    output logic                     instr_valid,
    output instr_t                   instr
);

    typedef enum logic [2:0] {
        IDLE,
        FETCH_HI,
        FETCH_LO,
        ISSUE,
        WAIT
    } state_e;

    state_e                   state;
    logic [IP_BITS-1:0]       ip;
    logic [MEM_DATA_BITS-1:0] ir_hi;

    // sequencer: hi read, lo read, issue, wait for execute
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            ip    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (run) begin
                        state <= FETCH_HI;
                    end
                end
                FETCH_HI: begin
                    ip    <= ip + 1'b1;
                    state <= FETCH_LO;
                end
                FETCH_LO: begin
                    ip    <= ip + 1'b1;
                    state <= ISSUE;
                end
                ISSUE: begin
                    state <= WAIT;
                end
                WAIT: begin
                    if (exec_done) begin
                        // taken branch overrides the incremented ip
                        if (redirect.taken) begin
                            ip <= redirect.target;
                        end
                        // run low lets the current instruction finish, then hold
                        state <= run ? FETCH_HI : IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // high byte lands on rd_data during FETCH_LO
    always_ff @(posedge clk) begin
        if (state == FETCH_LO) begin
            ir_hi <= rd_data;
        end
    end

    // addr always carries ip, execute reads it as next_ip
    always_comb begin
        fetch_req.re   = (state == FETCH_HI) || (state == FETCH_LO);
        fetch_req.we   = 1'b0;
        fetch_req.addr = ip;
        fetch_req.data = '0;
    end

    // low byte is on rd_data in ISSUE
    assign instr_valid = (state == ISSUE);
    assign instr       = instr_t'({ir_hi, rd_data});

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`default_nettype none
`timescale 1ns/1ns

module reg_file
    import cpu_isa_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [REG_ADDR_BITS-1:0] rs_addr,
    input  logic [REG_ADDR_BITS-1:0] rt_addr,
    input  logic [REG_ADDR_BITS-1:0] rd_addr,
    output logic [DATA_BITS-1:0]     rs_data,
    output logic [DATA_BITS-1:0]     rt_data,
    output logic [DATA_BITS-1:0]     rd_data,
    input  logic                     wr_en,
    input  logic [REG_ADDR_BITS-1:0] wr_addr,
    input  logic [DATA_BITS-1:0]     wr_data
);

    logic [DATA_BITS-1:0] regs [REG_COUNT];

    // all registers start at zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // three async read ports
    // rd read is for ADDI/SUBI and stores
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];
    assign rd_data = regs[rd_addr];

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module cpu_tb -Mdir obj_dir -f cpu_top.f
if [ $? -ne 0 ]; then
    echo "verilator compile step failed"
    exit 1
fi

./obj_dir/Vcpu_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    echo "simulation reported failures, see $LOG"
    exit 1
fi

echo "simulation finished cleanly, see $LOG"
exit 0
